//--- hdl/tdc_macros.svh
`ifndef TDC_MACROS_SVH
`define TDC_MACROS_SVH

// version byte returned at address 0
`define TDC_VERSION 8'd2

`define TDC_BASEADDR 16'h0000 // start of the register block
`define TDC_ABUSWIDTH 16

// identifier in the top nibble of every word
`define TDC_DATA_ID 4'd4

`define TDC_FIFO_DEPTH_LOG2 9 // 512 words

`endif

//--- hdl/tdc_pkg.sv
`default_nettype none

`include "tdc_macros.svh"

package tdc_pkg;

	typedef logic [31:0] tdc_word_t; // id, kind, event tag, value
	typedef logic [15:0] tdc_time_t; // all ones = saturated or no trigger
	typedef logic [15:0] tdc_stamp_t;

	typedef logic [7:0] bus_data_t;
	typedef logic [`TDC_ABUSWIDTH-1:0] bus_addr_t;

	typedef logic [7:0] cnt8_t; // saturates at 255
	typedef logic [31:0] cnt32_t;

	typedef enum logic [1:0] {
		kind_pulse = 2'd0,
		kind_stamp = 2'd1,
		kind_trig = 2'd2
	} word_kind_t;

	// word former sequence
	typedef enum logic [1:0] {
		idle,
		emit_pulse,
		emit_stamp,
		emit_trig
	} former_state_t;

endpackage

`default_nettype wire

//--- hdl/tdc_edge_capture.sv
`timescale 1ns/1ps
`default_nettype none

module tdc_edge_capture import tdc_pkg::*; (
	input logic BUS_CLK,
	input logic bus_clk_rst,
	input logic soft_rst,
	input logic capture_en,
	input logic inv_sig,
	input logic inv_trig,
	input logic tdc_in,
	input logic trig_in,
	input tdc_stamp_t timestamp,
	output logic event_valid,
	output logic event_taken,
	output tdc_time_t pulse_len,
	output tdc_time_t trig_dist,
	output tdc_stamp_t event_stamp
);

	logic rst;
	logic [2:0] sig_sh; // two sync flops plus edge history
	logic [2:0] trig_sh;
	logic sig_up, sig_dn, trig_up, trig_dn;
	logic sig_rise, sig_fall, trig_rise;
	logic start;
	logic active; // inside a measured pulse
	tdc_time_t len_cnt;
	tdc_time_t dist_cnt;

	assign rst = bus_clk_rst | soft_rst;

	always_ff @(posedge BUS_CLK) begin
		sig_sh <= {sig_sh[1:0], tdc_in};
		trig_sh <= {trig_sh[1:0], trig_in};
	end

	assign sig_up = sig_sh[1] & ~sig_sh[2];
	assign sig_dn = ~sig_sh[1] & sig_sh[2];
	assign trig_up = trig_sh[1] & ~trig_sh[2];
	assign trig_dn = ~trig_sh[1] & trig_sh[2];

	// inversion swaps edges, so toggling it never fakes a pulse
	assign sig_rise = inv_sig ? sig_dn : sig_up;
	assign sig_fall = inv_sig ? sig_up : sig_dn;
	assign trig_rise = inv_trig ? trig_dn : trig_up;

	assign start = sig_rise & capture_en & ~active;

	always_ff @(posedge BUS_CLK) begin
		if (rst)
			dist_cnt <= '1; // no trigger seen yet
		else if (trig_rise)
			dist_cnt <= tdc_time_t'(1);
		else if (dist_cnt != '1)
			dist_cnt <= dist_cnt + 1'b1;
	end

	always_ff @(posedge BUS_CLK) begin
		if (rst) begin
			active <= 1'b0;
			event_valid <= 1'b0;
			event_taken <= 1'b0;
		end else begin
			event_valid <= active & sig_fall;
			event_taken <= start; // clears the arm latch
			if (start)
				active <= 1'b1;
			else if (sig_fall)
				active <= 1'b0;
		end
	end

	always_ff @(posedge BUS_CLK) begin
		if (start) begin
			len_cnt <= tdc_time_t'(1);
			event_stamp <= timestamp;
			trig_dist <= trig_rise ? '0 : dist_cnt; // same-cycle trigger is distance 0
		end else if (active && len_cnt != '1) begin
			len_cnt <= len_cnt + 1'b1;
		end
		if (active && sig_fall)
			pulse_len <= len_cnt;
	end

	assert property (@(posedge BUS_CLK) disable iff (rst) event_valid |=> !event_valid)
		else $error("event_valid high on two consecutive cycles");

endmodule

`default_nettype wire

//--- hdl/tdc_word_former.sv
`timescale 1ns/1ps
`default_nettype none

`include "tdc_macros.svh"

module tdc_word_former import tdc_pkg::*; (
	input logic BUS_CLK,
	input logic bus_clk_rst,
	input logic soft_rst,
	input logic en_write_timestamp,
	input logic en_trig_distance,
	input logic event_valid,
	input tdc_time_t pulse_len,
	input tdc_time_t trig_dist,
	input tdc_stamp_t event_stamp,
	output logic word_valid,
	output tdc_word_t word,
	output cnt32_t event_cnt,
	output cnt8_t miss_cnt
);

	localparam int unsigned TAG_W = 10;

	former_state_t state, state_next;
	tdc_word_t word_next;
	logic rst;
	logic accept;
	logic [TAG_W-1:0] tag_q; // event number of the word group
	tdc_stamp_t stamp_q;
	tdc_time_t dist_q;

	function automatic tdc_word_t make_word(
		input word_kind_t kind,
		input logic [TAG_W-1:0] tag,
		input logic [15:0] value
	);
		make_word = {`TDC_DATA_ID, kind, tag, value};
	endfunction

	assign rst = bus_clk_rst | soft_rst;
	assign accept = event_valid && (state == idle);

	always_comb begin
		state_next = idle;
		word_next = word;
		case (state)
			idle: if (event_valid) begin
				state_next = emit_pulse;
				word_next = make_word(kind_pulse, event_cnt[TAG_W-1:0], pulse_len);
			end
			emit_pulse: if (en_write_timestamp) begin
				state_next = emit_stamp;
				word_next = make_word(kind_stamp, tag_q, stamp_q);
			end else if (en_trig_distance) begin
				state_next = emit_trig;
				word_next = make_word(kind_trig, tag_q, dist_q);
			end
			emit_stamp: if (en_trig_distance) begin
				state_next = emit_trig;
				word_next = make_word(kind_trig, tag_q, dist_q);
			end
			default: state_next = idle; // trigger word is always last
		endcase
	end

	always_ff @(posedge BUS_CLK) begin
		if (rst) begin
			state <= idle;
			word_valid <= 1'b0;
			event_cnt <= '0;
			miss_cnt <= '0;
		end else begin
			state <= state_next;
			word_valid <= (state_next != idle);
			if (accept)
				event_cnt <= event_cnt + 1'b1;
			if (event_valid && state != idle && miss_cnt != '1)
				miss_cnt <= miss_cnt + 1'b1; // busy, event dropped
		end
	end

	always_ff @(posedge BUS_CLK) begin
		word <= word_next;
		if (accept) begin
			tag_q <= event_cnt[TAG_W-1:0];
			stamp_q <= event_stamp;
			dist_q <= trig_dist;
		end
	end

	// every emitted word belongs to the group being worked on
	assert property (@(posedge BUS_CLK) disable iff (rst)
		word_valid |-> (state != idle) && (word[25:16] == tag_q))
		else $error("word_valid while the former is idle or with a stale event tag");

endmodule

`default_nettype wire

//--- hdl/tdc_data_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "tdc_macros.svh"

module tdc_data_fifo import tdc_pkg::*; (
	input logic BUS_CLK,
	input logic bus_clk_rst,
	input logic soft_rst,
	input logic word_valid,
	input tdc_word_t word,
	input logic fifo_read,
	output logic fifo_empty,
	output tdc_word_t fifo_data,
	output cnt8_t lost_cnt
);

	localparam int unsigned AW = `TDC_FIFO_DEPTH_LOG2;

	tdc_word_t mem [2**AW];
	logic [AW:0] wr_ptr; // extra bit tells full from empty
	logic [AW:0] rd_ptr;
	logic rst;
	logic full;
	logic do_write, do_read;

	assign rst = bus_clk_rst | soft_rst;

	assign fifo_empty = (wr_ptr == rd_ptr);
	assign full = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
	assign do_write = word_valid && !full;
	assign do_read = fifo_read && !fifo_empty;

	assign fifo_data = mem[rd_ptr[AW-1:0]]; // first word falls through

	always_ff @(posedge BUS_CLK) begin
		if (do_write)
			mem[wr_ptr[AW-1:0]] <= word;
	end

	always_ff @(posedge BUS_CLK) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			lost_cnt <= '0;
		end else begin
			if (do_write)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_read)
				rd_ptr <= rd_ptr + 1'b1;
			if (word_valid && full && lost_cnt != '1)
				lost_cnt <= lost_cnt + 1'b1;
		end
	end

	assert property (@(posedge BUS_CLK) disable iff (rst) fifo_read |-> !fifo_empty)
		else $error("fifo_read while the FIFO is empty");

endmodule

`default_nettype wire

//--- hdl/tdc_reg_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "tdc_macros.svh"

module tdc_reg_bank import tdc_pkg::*; (
	input logic BUS_CLK,
	input logic bus_clk_rst,
	input bus_addr_t bus_add,
	input bus_data_t bus_data_in,
	input logic bus_wr,
	input logic bus_rd,
	output bus_data_t bus_data_out,
	input logic arm_tdc,
	input logic ext_en,
	input logic event_taken,
	input cnt32_t event_cnt,
	input cnt8_t miss_cnt,
	input cnt8_t lost_cnt,
	output logic soft_rst,
	output logic capture_en,
	output logic en_write_timestamp,
	output logic en_trig_distance,
	output logic inv_sig,
	output logic inv_trig
);

	localparam int unsigned REG_COUNT = 9;

	bus_addr_t rel_add;
	logic hit;
	logic wr_en, rd_en;
	logic rst;
	bus_data_t ctrl; // control byte at address 1
	logic armed;
	bus_data_t rd_byte;

	assign rel_add = bus_add - bus_addr_t'(`TDC_BASEADDR);
	assign hit = (rel_add < bus_addr_t'(REG_COUNT));
	assign wr_en = bus_wr && hit;
	assign rd_en = bus_rd && hit;
	assign rst = bus_clk_rst | soft_rst;

	always_ff @(posedge BUS_CLK) begin
		if (bus_clk_rst)
			soft_rst <= 1'b0;
		else
			soft_rst <= wr_en && (rel_add == bus_addr_t'(0));
	end

	always_ff @(posedge BUS_CLK) begin
		if (rst) begin
			ctrl <= '0;
			armed <= 1'b0;
		end else begin
			if (wr_en && rel_add == bus_addr_t'(1))
				ctrl <= bus_data_in;
			if (arm_tdc || (wr_en && rel_add == bus_addr_t'(2)))
				armed <= 1'b1;
			else if (event_taken)
				armed <= 1'b0; // one pulse per arm
		end
	end

	// in arm mode the enable only counts while armed
	assign capture_en = (ctrl[0] | ext_en) & (~ctrl[1] | armed);
	assign en_write_timestamp = ctrl[2];
	assign en_trig_distance = ctrl[3];
	assign inv_sig = ctrl[4];
	assign inv_trig = ctrl[5];

	always_comb begin
		case (rel_add[3:0])
			4'd0: rd_byte = `TDC_VERSION;
			4'd1: rd_byte = ctrl;
			4'd2: rd_byte = {7'b0, armed};
			4'd3: rd_byte = event_cnt[7:0]; // lsb first
			4'd4: rd_byte = event_cnt[15:8];
			4'd5: rd_byte = event_cnt[23:16];
			4'd6: rd_byte = event_cnt[31:24];
			4'd7: rd_byte = miss_cnt;
			4'd8: rd_byte = lost_cnt;
			default: rd_byte = '0;
		endcase
	end

	always_ff @(posedge BUS_CLK) begin
		if (bus_clk_rst)
			bus_data_out <= '0;
		else if (rd_en)
			bus_data_out <= rd_byte; // held until the next read
	end

endmodule

`default_nettype wire

//--- hdl/tdc_top.sv
`timescale 1ns/1ps
`default_nettype none

module tdc_top import tdc_pkg::*; (
	input logic BUS_CLK,
	input logic bus_clk_rst,
	input bus_addr_t bus_add,
	input bus_data_t bus_data_in,
	output bus_data_t bus_data_out,
	input logic bus_wr,
	input logic bus_rd,
	input logic tdc_in,
	input logic trig_in,
	input tdc_stamp_t timestamp,
	input logic arm_tdc,
	input logic ext_en,
	input logic fifo_read,
	output logic fifo_empty,
	output tdc_word_t fifo_data
);

	logic soft_rst;
	logic capture_en;
	logic en_write_timestamp, en_trig_distance;
	logic inv_sig, inv_trig;
	logic event_valid, event_taken;
	tdc_time_t pulse_len, trig_dist;
	tdc_stamp_t event_stamp;
	logic word_valid;
	tdc_word_t word;
	cnt32_t event_cnt;
	cnt8_t miss_cnt, lost_cnt;

	tdc_reg_bank reg_bank_i (
		.BUS_CLK(BUS_CLK),
		.bus_clk_rst(bus_clk_rst),
		.bus_add(bus_add),
		.bus_data_in(bus_data_in),
		.bus_wr(bus_wr),
		.bus_rd(bus_rd),
		.bus_data_out(bus_data_out),
		.arm_tdc(arm_tdc),
		.ext_en(ext_en),
		.event_taken(event_taken),
		.event_cnt(event_cnt),
		.miss_cnt(miss_cnt),
		.lost_cnt(lost_cnt),
		.soft_rst(soft_rst),
		.capture_en(capture_en),
		.en_write_timestamp(en_write_timestamp),
		.en_trig_distance(en_trig_distance),
		.inv_sig(inv_sig),
		.inv_trig(inv_trig)
	);

	tdc_edge_capture edge_capture_i (
		.BUS_CLK(BUS_CLK),
		.bus_clk_rst(bus_clk_rst),
		.soft_rst(soft_rst),
		.capture_en(capture_en),
		.inv_sig(inv_sig),
		.inv_trig(inv_trig),
		.tdc_in(tdc_in),
		.trig_in(trig_in),
		.timestamp(timestamp),
		.event_valid(event_valid),
		.event_taken(event_taken),
		.pulse_len(pulse_len),
		.trig_dist(trig_dist),
		.event_stamp(event_stamp)
	);

	tdc_word_former word_former_i (
		.BUS_CLK(BUS_CLK),
		.bus_clk_rst(bus_clk_rst),
		.soft_rst(soft_rst),
		.en_write_timestamp(en_write_timestamp),
		.en_trig_distance(en_trig_distance),
		.event_valid(event_valid),
		.pulse_len(pulse_len),
		.trig_dist(trig_dist),
		.event_stamp(event_stamp),
		.word_valid(word_valid),
		.word(word),
		.event_cnt(event_cnt),
		.miss_cnt(miss_cnt)
	);

	tdc_data_fifo data_fifo_i (
		.BUS_CLK(BUS_CLK),
		.bus_clk_rst(bus_clk_rst),
		.soft_rst(soft_rst),
		.word_valid(word_valid),
		.word(word),
		.fifo_read(fifo_read),
		.fifo_empty(fifo_empty),
		.fifo_data(fifo_data),
		.lost_cnt(lost_cnt)
	);

endmodule

`default_nettype wire

//--- sim/tb_tdc_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tdc_top import tdc_pkg::*; ();

	localparam int TIMEOUT_CYCLES = 20000; // whole run needs about 3500 cycles
	localparam int WORD_WAIT = 16;
	localparam int DRAIN_CYCLES = 8; // sync 2, event 1, former 3, fifo 1, plus one spare
	localparam int RAND_PULSES = 12;
	localparam int BULK_PULSES = 520;
	localparam int FIFO_WORDS = 512;

	logic BUS_CLK;
	logic bus_clk_rst;
	bus_addr_t bus_add;
	bus_data_t bus_data_in;
	bus_data_t bus_data_out;
	logic bus_wr, bus_rd;
	logic tdc_in, trig_in;
	tdc_stamp_t timestamp;
	logic arm_tdc, ext_en;
	logic fifo_read;
	logic fifo_empty;
	tdc_word_t fifo_data;

	int err_cnt, check_cnt, tests_run, cycle_cnt;
	int ev_expected; // event tag the next accepted pulse should carry
	integer seed;
	logic sig_idle; // resting level of tdc_in

	tdc_top tdc_top_i (
		.BUS_CLK(BUS_CLK),
		.bus_clk_rst(bus_clk_rst),
		.bus_add(bus_add),
		.bus_data_in(bus_data_in),
		.bus_data_out(bus_data_out),
		.bus_wr(bus_wr),
		.bus_rd(bus_rd),
		.tdc_in(tdc_in),
		.trig_in(trig_in),
		.timestamp(timestamp),
		.arm_tdc(arm_tdc),
		.ext_en(ext_en),
		.fifo_read(fifo_read),
		.fifo_empty(fifo_empty),
		.fifo_data(fifo_data)
	);

	always #20 BUS_CLK = ~BUS_CLK;

	always @(posedge BUS_CLK) begin
		cycle_cnt++;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("ERROR: timeout after %0d cycles, the tests did not finish", cycle_cnt);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	task automatic next_cycle;
		@(posedge BUS_CLK);
		#1;
	endtask

	task automatic check_word(input string name, input tdc_word_t exp, input tdc_word_t act);
		check_cnt++;
		if (act !== exp) begin
			err_cnt++;
			$display("MISMATCH at %0t ns: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_byte(input string name, input bus_data_t exp, input bus_data_t act);
		check_cnt++;
		if (act !== exp) begin
			err_cnt++;
			$display("MISMATCH at %0t ns: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_time(input string name, input tdc_time_t exp, input tdc_time_t act);
		check_cnt++;
		if (act !== exp) begin
			err_cnt++;
			$display("MISMATCH at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
		end
	endtask

	// id 4, kind, 10-bit event tag, 16-bit value
	function automatic tdc_word_t expected_word(input word_kind_t kind, input int tag,
		input logic [15:0] value);
		expected_word = {4'd4, kind, tag[9:0], value};
	endfunction

	task automatic bus_write(input bus_addr_t addr, input bus_data_t data);
		bus_add = addr;
		bus_data_in = data;
		bus_wr = 1'b1;
		next_cycle;
		bus_wr = 1'b0;
	endtask

	task automatic bus_read(input bus_addr_t addr, output bus_data_t data);
		bus_add = addr;
		bus_rd = 1'b1;
		next_cycle;
		bus_rd = 1'b0;
		data = bus_data_out; // registered on the read edge
	endtask

	// trig_gap of 0 means no trigger before the pulse
	task automatic make_pulse(input int len, input int trig_gap);
		if (trig_gap > 0) begin
			trig_in = 1'b1;
			next_cycle;
			trig_in = 1'b0;
			repeat (trig_gap - 1) next_cycle;
		end
		tdc_in = ~sig_idle;
		repeat (len) next_cycle;
		tdc_in = sig_idle;
		repeat (2) next_cycle; // shortest gap between pulses
	endtask

	task automatic pop_word(output tdc_word_t w, output logic got);
		int waited;
		waited = 0;
		while (fifo_empty && waited < WORD_WAIT) begin
			next_cycle;
			waited++;
		end
		if (fifo_empty) begin
			err_cnt++;
			$display("ERROR at %0t ns: expected a word but the FIFO stayed empty", $time);
			w = '0;
			got = 1'b0;
		end else begin
			w = fifo_data;
			got = 1'b1;
			fifo_read = 1'b1;
			next_cycle;
			fifo_read = 1'b0;
		end
	endtask

	task automatic expect_no_word;
		repeat (DRAIN_CYCLES) next_cycle;
		if (!fifo_empty) begin
			err_cnt++;
			$display("ERROR at %0t ns: unexpected word %h in the FIFO", $time, fifo_data);
		end
	endtask

	task automatic pop_and_check(input string name, input word_kind_t kind,
		input logic [15:0] value);
		tdc_word_t w;
		logic got;
		pop_word(w, got);
		if (got)
			check_word(name, expected_word(kind, ev_expected, value), w);
	endtask

	task automatic finish_test(input string name, input int errs_at_start);
		tests_run++;
		$display("%s: %0d errors", name, err_cnt - errs_at_start);
	endtask

	task automatic test_registers;
		bus_data_t d;
		int errs;
		errs = err_cnt;
		bus_read(16'd0, d);
		check_byte("bus_data_out (version)", 8'd2, d);
		bus_write(16'd1, 8'h2A);
		bus_read(16'd1, d);
		check_byte("bus_data_out (control)", 8'h2A, d);
		bus_write(16'd1, 8'h00);
		bus_read(16'd1, d);
		check_byte("bus_data_out (control)", 8'h00, d);
		finish_test("register access", errs);
	endtask

	task automatic test_pulse_length;
		tdc_word_t w;
		logic got;
		int len;
		int errs;
		errs = err_cnt;
		bus_write(16'd1, 8'h01); // enable only
		for (int i = 0; i < RAND_PULSES; i++) begin
			len = 3 + ($unsigned($random(seed)) % 38);
			make_pulse(len, 0);
			pop_word(w, got);
			if (got) begin
				check_word("fifo_data", expected_word(kind_pulse, ev_expected,
					tdc_time_t'(len)), w);
				check_time("pulse length", tdc_time_t'(len), w[15:0]);
			end
			ev_expected++;
			expect_no_word;
		end
		finish_test("pulse measurement", errs);
	endtask

	task automatic test_optional_words;
		tdc_word_t w;
		logic got;
		int errs;
		errs = err_cnt;
		timestamp = 16'hA5C3;
		bus_write(16'd1, 8'h0D); // enable, timestamp and trigger words
		make_pulse(5, 7);
		pop_and_check("fifo_data (pulse)", kind_pulse, 16'd5);
		pop_and_check("fifo_data (stamp)", kind_stamp, 16'hA5C3);
		pop_word(w, got);
		if (got) begin
			check_word("fifo_data (trig)", expected_word(kind_trig, ev_expected, 16'd7), w);
			check_time("trigger distance", 16'd7, w[15:0]);
		end
		ev_expected++;
		expect_no_word;
		bus_write(16'd1, 8'h00);
		finish_test("optional words", errs);
	endtask

	task automatic test_arm_invert;
		int errs;
		errs = err_cnt;
		bus_write(16'd1, 8'h03); // enable in arm mode
		make_pulse(6, 0);
		expect_no_word; // not armed yet
		arm_tdc = 1'b1;
		next_cycle;
		arm_tdc = 1'b0;
		make_pulse(8, 0);
		pop_and_check("fifo_data (armed)", kind_pulse, 16'd8);
		ev_expected++;
		expect_no_word;
		make_pulse(9, 0);
		expect_no_word; // arm used up by the first pulse
		bus_write(16'd1, 8'h10);
		sig_idle = 1'b1;
		tdc_in = 1'b1;
		repeat (4) next_cycle;
		bus_write(16'd1, 8'h11);
		make_pulse(12, 0); // low-going
		pop_and_check("fifo_data (inverted)", kind_pulse, 16'd12);
		ev_expected++;
		expect_no_word;
		bus_write(16'd1, 8'h10);
		sig_idle = 1'b0;
		tdc_in = 1'b0;
		repeat (4) next_cycle;
		bus_write(16'd1, 8'h00);
		finish_test("arm mode and inversion", errs);
	endtask

	task automatic test_counters;
		bus_data_t d;
		cnt32_t ev32;
		int errs;
		errs = err_cnt;
		bus_write(16'd0, 8'h00); // soft reset
		next_cycle;
		ev_expected = 0;
		bus_write(16'd1, 8'h01);
		for (int i = 0; i < BULK_PULSES; i++)
			make_pulse(2, 0);
		repeat (DRAIN_CYCLES) next_cycle;
		bus_read(16'd8, d);
		check_byte("bus_data_out (lost count)", bus_data_t'(BULK_PULSES - FIFO_WORDS), d);
		ev32 = cnt32_t'(BULK_PULSES);
		for (int k = 0; k < 4; k++) begin
			bus_read(bus_addr_t'(3 + k), d);
			check_byte("bus_data_out (event count)", ev32[8*k +: 8], d);
		end
		bus_write(16'd1, 8'h0D);
		repeat (10) make_pulse(1, 0); // three words each, faster than the former
		repeat (DRAIN_CYCLES) next_cycle;
		bus_read(16'd7, d);
		check_cnt++;
		if (d == 8'd0) begin
			err_cnt++;
			$display("ERROR at %0t ns: miss count stayed at zero after fast pulses", $time);
		end
		bus_write(16'd0, 8'h00);
		next_cycle;
		for (int k = 3; k <= 8; k++) begin
			bus_read(bus_addr_t'(k), d);
			check_byte("bus_data_out (counter after soft reset)", 8'h00, d);
		end
		bus_read(16'd1, d);
		check_byte("bus_data_out (control after soft reset)", 8'h00, d);
		check_cnt++;
		if (!fifo_empty) begin
			err_cnt++;
			$display("ERROR at %0t ns: FIFO not empty after soft reset", $time);
		end
		finish_test("counters and soft reset", errs);
	endtask

	initial begin
		BUS_CLK = 1'b0;
		bus_clk_rst = 1'b1;
		bus_add = '0;
		bus_data_in = '0;
		bus_wr = 1'b0;
		bus_rd = 1'b0;
		tdc_in = 1'b0;
		trig_in = 1'b0;
		timestamp = '0;
		arm_tdc = 1'b0;
		ext_en = 1'b0;
		fifo_read = 1'b0;
		sig_idle = 1'b0;
		seed = 25316;
		err_cnt = 0;
		check_cnt = 0;
		tests_run = 0;
		cycle_cnt = 0;
		ev_expected = 0;
		repeat (2) @(posedge BUS_CLK);
		#1;
		bus_clk_rst = 1'b0;
		repeat (4) next_cycle; // fill the synchronizers
		test_registers;
		test_pulse_length;
		test_optional_words;
		test_arm_invert;
		test_counters;
		$display("tests: %0d, checks: %0d, errors: %0d", tests_run, check_cnt, err_cnt);
		if (err_cnt == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- tdc_top.f
+incdir+hdl
hdl/tdc_pkg.sv
hdl/tdc_edge_capture.sv
hdl/tdc_word_former.sv
hdl/tdc_data_fifo.sv
hdl/tdc_reg_bank.sv
hdl/tdc_top.sv
sim/tb_tdc_top.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the TDC readout testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f tdc_top.f \
	--top-module tb_tdc_top \
	-o tb_tdc_top

out=$(./obj_dir/tb_tdc_top || true)
echo "$out"

if echo "$out" | grep -q "TESTBENCH PASSED"; then
	exit 0
else
	exit 1
fi
